// ==== common/ioBusPkg.sv ====
`default_nettype none

package ioBusPkg;

    ////////////////////
    // Bus geometry
    ////////////////////

    // Address and data share one width
    localparam int busWidth = 32;

    ////////////////////
    // Device map
    ////////////////////

    localparam logic [busWidth-1:0] ledAddr    = 32'hFFFF_FC60;
    localparam logic [busWidth-1:0] switchAddr = 32'hFFFF_FC70;
    localparam logic [busWidth-1:0] segAddr    = 32'hFFFF_FC80;

    ////////////////////
    // Bus records
    ////////////////////

    // One request as issued by the core side
    typedef struct packed {
        logic [busWidth-1:0] addr;
        logic [busWidth-1:0] wdata;
        logic                we;
    } ioReq;

    // Write strobe plus data for a single device
    typedef struct packed {
        logic                we;
        logic [busWidth-1:0] data;
    } regWrite;

endpackage

`default_nettype wire

// ==== common/displayPkg.sv ====
`default_nettype none

package displayPkg;

    ////////////////////
    // Scan timing
    ////////////////////

    localparam int digitCount = 8;
    localparam int digitWidth = $clog2(digitCount);

    // Cycles each digit stays lit, kept small for short runs
    localparam int scanDivider = 4;
    localparam int scanWidth   = $clog2(scanDivider);

    ////////////////////
    // Hex font
    ////////////////////

    // Active low cathodes, gfedcba, entry 15 first
    localparam logic [15:0][6:0] segFont = {
        7'h0E,  // F
        7'h06,  // E
        7'h21,  // d
        7'h46,  // C
        7'h03,  // b
        7'h08,  // A
        7'h10,  // 9
        7'h00,  // 8
        7'h78,  // 7
        7'h02,  // 6
        7'h12,  // 5
        7'h19,  // 4
        7'h30,  // 3
        7'h24,  // 2
        7'h79,  // 1
        7'h40   // 0
    };

endpackage

`default_nettype wire

// ==== verilog/peripheralConnector.sv ====
`default_nettype none

module peripheralConnector
    import ioBusPkg::*;
(
    input  ioReq                bus,
    input  logic [15:0]         SW,
    input  logic [15:0]         ledValue,
    input  logic [31:0]         segValue,
    output logic [busWidth-1:0] rdata,
    output regWrite             ledWrite,
    output regWrite             segWrite
);

    logic ledHit;
    logic segHit;

    ////////////////////
    // Write decode
    ////////////////////

    assign ledHit = (bus.addr == ledAddr);
    assign segHit = (bus.addr == segAddr);

    // Switch address and unmapped space get no strobe
    assign ledWrite.we   = bus.we && ledHit;
    assign ledWrite.data = bus.wdata;

    assign segWrite.we   = bus.we && segHit;
    assign segWrite.data = bus.wdata;

    ////////////////////
    // Read mux
    ////////////////////

    always_comb begin
        case (bus.addr)
            switchAddr: rdata = busWidth'(SW);
            ledAddr:    rdata = busWidth'(ledValue);
            segAddr:    rdata = segValue;
            default:    rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/ledDriver.sv ====
`default_nettype none

module ledDriver
    import ioBusPkg::*;
(
    input  logic        CLK,
    input  logic        rstN,
    input  regWrite     ledWrite,
    output logic [15:0] LED
);

    logic [15:0] ledReg;

    // Only the low half of the bus word reaches the LEDs
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            ledReg <= '0;
        end else if (ledWrite.we) begin
            ledReg <= ledWrite.data[15:0];
        end
    end

    assign LED = ledReg;

endmodule

`default_nettype wire

// ==== segment/segmentDriver.sv ====
`default_nettype none

module segmentDriver
    import ioBusPkg::*;
(
    input  logic                CLK,
    input  logic                rstN,
    input  regWrite             segWrite,
    output logic [busWidth-1:0] segValue
);

    logic [busWidth-1:0] segReg;

    ////////////////////
    // Display word
    ////////////////////

    // Eight hex digits, digit 0 in the low nibble
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            segReg <= '0;
        end else if (segWrite.we) begin
            segReg <= segWrite.data;
        end
    end

    assign segValue = segReg;

endmodule

`default_nettype wire

// ==== segment/segmentScanner.sv ====
`default_nettype none

module segmentScanner
    import displayPkg::*;
(
    input  logic                  CLK,
    input  logic                  rstN,
    input  logic [31:0]           segValue,
    output logic [digitCount-1:0] anode,
    output logic [6:0]            cathode
);

    localparam logic [scanWidth-1:0] scanLast = scanWidth'(scanDivider - 1);

    logic [scanWidth-1:0]  scanCnt;
    logic [digitWidth-1:0] digitIdx;
    logic [3:0]            nibble;

    ////////////////////
    // Scan divider
    ////////////////////

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            scanCnt <= '0;
        end else if (scanCnt == scanLast) begin
            scanCnt <= '0;
        end else begin
            scanCnt <= scanCnt + 1'b1;
        end
    end

    ////////////////////
    // Digit counter
    ////////////////////

    // Steps once per divider wrap, 7 rolls over to 0
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            digitIdx <= '0;
        end else if (scanCnt == scanLast) begin
            digitIdx <= digitIdx + 1'b1;
        end
    end

    ////////////////////
    // Digit outputs
    ////////////////////

    // Nibble for the digit under the counter
    assign nibble = segValue[digitIdx * 4 +: 4];

    // Anode and cathode share one register stage
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            anode   <= ~digitCount'(1);
            // Display word is zero after reset as well
            cathode <= segFont[0];
        end else begin
            anode   <= ~(digitCount'(1) << digitIdx);
            cathode <= segFont[nibble];
        end
    end

    // Lit digit only ever moves up one place
    assert property (
        @(posedge CLK) disable iff (!rstN)
        $changed(anode) |->
            (anode == {$past(anode[digitCount-2:0]), $past(anode[digitCount-1])})
    ) else $error("anode did not step to the next digit");

endmodule

`default_nettype wire

// ==== verilog/peripheralTop.sv ====
`default_nettype none

module peripheralTop
    import ioBusPkg::*;
    import displayPkg::*;
(
    input  logic                  CLK,
    input  logic                  rstN,
    input  ioReq                  bus,
    output logic [busWidth-1:0]   rdata,
    input  logic [15:0]           SW,
    output logic [15:0]           LED,
    output logic [digitCount-1:0] SevenSegAn,
    output logic [6:0]            SevenSegCat
);

    regWrite             ledWrite;
    regWrite             segWrite;
    logic [15:0]         ledValue;
    logic [busWidth-1:0] segValue;

    peripheralConnector peripheralConnector (
        .bus      (bus),
        .SW       (SW),
        .ledValue (ledValue),
        .segValue (segValue),
        .rdata    (rdata),
        .ledWrite (ledWrite),
        .segWrite (segWrite)
    );

    ////////////////////
    // Peripherals
    ////////////////////

    ledDriver ledDriver (
        .CLK      (CLK),
        .rstN     (rstN),
        .ledWrite (ledWrite),
        .LED      (ledValue)
    );

    // LED register also feeds readback
    assign LED = ledValue;

    segmentDriver segmentDriver (
        .CLK      (CLK),
        .rstN     (rstN),
        .segWrite (segWrite),
        .segValue (segValue)
    );

    segmentScanner segmentScanner (
        .CLK      (CLK),
        .rstN     (rstN),
        .segValue (segValue),
        .anode    (SevenSegAn),
        .cathode  (SevenSegCat)
    );

endmodule

`default_nettype wire

// ==== tb/peripheralChecker.sv ====
`default_nettype none

module peripheralChecker
    import ioBusPkg::*;
    import displayPkg::*;
(
    input  logic                  CLK,
    input  logic                  rstN,
    input  ioReq                  bus,
    input  logic [busWidth-1:0]   rdata,
    input  logic [15:0]           LED,
    input  logic [digitCount-1:0] anode,
    input  logic [6:0]            cathode,
    input  logic                  opValid,
    input  logic                  opIsRead,
    input  int                    opIndex,
    input  logic [31:0]           expRdata,
    output int                    passCount,
    output int                    failCount,
    output logic                  displayDone
);

    localparam int scanSpan = digitCount * scanDivider;

    // Register contents as the bus rules predict them
    logic [15:0]           ledModel;
    logic [31:0]           segModel;
    int                    settle;
    int                    cycle;
    int                    seenAt [digitCount];
    logic [digitCount-1:0] verified;

    task automatic reportFail(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        failCount++;
    endtask

    ////////////////////
    // Compare
    ////////////////////

    // Sampled mid cycle, well clear of the drive edge
    always @(negedge CLK) begin : compare
        int         zeros;
        int         lit;
        int         prevFails;
        logic [6:0] wantCat;
        if (!rstN) begin
            ledModel  = '0;
            segModel  = '0;
            settle    = scanSpan + 2;
            cycle     = 0;
            verified  = '0;
            passCount = 0;
            failCount = 0;
            for (int k = 0; k < digitCount; k++) begin
                seenAt[k] = 0;
            end
        end else begin
            prevFails = failCount;
            cycle++;
            if (LED !== ledModel) begin
                reportFail($sformatf("LED is %h, expected %h", LED, ledModel));
            end
            zeros = 0;
            lit   = 0;
            for (int k = 0; k < digitCount; k++) begin
                if (anode[k] !== 1'b1) begin
                    zeros++;
                    lit = k;
                end
            end
            if (zeros != 1) begin
                reportFail($sformatf("anode %b selects %0d digits", anode, zeros));
            end else begin
                seenAt[lit] = cycle;
                // Cathode only trusted once a full scan has passed
                if (settle == 0) begin
                    wantCat = segFont[segModel[lit*4 +: 4]];
                    if (cathode !== wantCat) begin
                        reportFail($sformatf("digit %0d cathode %h, expected %h",
                                             lit, cathode, wantCat));
                    end else begin
                        verified[lit] = 1'b1;
                    end
                end
            end
            for (int k = 0; k < digitCount; k++) begin
                if (cycle - seenAt[k] >= scanSpan) begin
                    reportFail($sformatf("digit %0d not lit within %0d cycles", k, scanSpan));
                    seenAt[k] = cycle;
                end
            end
            if (settle > 0) begin
                settle--;
            end
            if (opValid) begin
                if (opIsRead && rdata !== expRdata) begin
                    reportFail($sformatf("read %h returned %h, expected %h",
                                         bus.addr, rdata, expRdata));
                end
                if (failCount == prevFails) begin
                    passCount++;
                    $display("op %0d %s %h passed", opIndex + 1, opIsRead ? "R" : "W", bus.addr);
                end else begin
                    $display("op %0d %s %h failed", opIndex + 1, opIsRead ? "R" : "W", bus.addr);
                end
            end
            // Write lands on the coming edge
            if (bus.we === 1'b1) begin
                if (bus.addr == ledAddr) begin
                    ledModel = bus.wdata[15:0];
                end
                if (bus.addr == segAddr) begin
                    segModel = bus.wdata;
                    settle   = scanSpan + 2;
                    verified = '0;
                end
            end
        end
    end

    assign displayDone = (settle == 0) && (verified == '1);

endmodule

`default_nettype wire

// ==== tb/peripheralTb.sv ====
`default_nettype none

module peripheralTb
    import ioBusPkg::*;
    import displayPkg::*;
();

    logic                  CLK;
    logic                  rstN;
    ioReq                  bus;
    logic [busWidth-1:0]   rdata;
    logic [15:0]           SW;
    logic [15:0]           LED;
    logic [digitCount-1:0] SevenSegAn;
    logic [6:0]            SevenSegCat;

    // Per operation info handed to the checker
    logic        opValid;
    logic        opIsRead;
    int          opIndex;
    logic [31:0] expRdata;
    int          passCount;
    int          failCount;
    logic        displayDone;

    bit loaded;
    int lineCount;

    // Golden operations, one entry per file line
    logic        opRead [$];
    logic [31:0] opAddr [$];
    logic [31:0] opData [$];
    logic [15:0] opSw [$];
    logic [31:0] opExp [$];

    peripheralTop UUT (
        .CLK         (CLK),
        .rstN        (rstN),
        .bus         (bus),
        .rdata       (rdata),
        .SW          (SW),
        .LED         (LED),
        .SevenSegAn  (SevenSegAn),
        .SevenSegCat (SevenSegCat)
    );

    peripheralChecker scoreboard (
        .CLK         (CLK),
        .rstN        (rstN),
        .bus         (bus),
        .rdata       (rdata),
        .LED         (LED),
        .anode       (SevenSegAn),
        .cathode     (SevenSegCat),
        .opValid     (opValid),
        .opIsRead    (opIsRead),
        .opIndex     (opIndex),
        .expRdata    (expRdata),
        .passCount   (passCount),
        .failCount   (failCount),
        .displayDone (displayDone)
    );

    initial begin : clockGen
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    ////////////////////
    // Golden file
    ////////////////////

    // Lines starting with # are notes
    task automatic loadGolden(output bit ok);
        int          fd;
        int          got;
        string       line;
        logic [7:0]  opChar;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [15:0] sw;
        logic [31:0] wantData;
        ok = 1'b1;
        fd = $fopen("tb/peripheralGolden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open tb/peripheralGolden.txt");
            ok = 1'b0;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    got = $sscanf(line, "%c %h %h %h %h", opChar, addr, wdata, sw, wantData);
                    if (got != 5 || (opChar != "R" && opChar != "W")) begin
                        $display("Malformed golden line: %s", line);
                        ok = 1'b0;
                    end else begin
                        opRead.push_back(opChar == "R");
                        opAddr.push_back(addr);
                        opData.push_back(wdata);
                        opSw.push_back(sw);
                        opExp.push_back(wantData);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic driveOp(input int idx);
        @(posedge CLK);
        #1;
        bus.addr  = opAddr[idx];
        bus.wdata = opData[idx];
        bus.we    = !opRead[idx];
        SW        = opSw[idx];
        opValid   = 1'b1;
        opIsRead  = opRead[idx];
        opIndex   = idx;
        expRdata  = opExp[idx];
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin : stimulus
        bit ok;
        rstN      = 1'b0;
        bus       = '0;
        SW        = '0;
        opValid   = 1'b0;
        opIsRead  = 1'b0;
        opIndex   = 0;
        expRdata  = '0;
        loaded    = 1'b0;
        lineCount = 0;
        loadGolden(ok);
        if (!ok) begin
            $display("Golden file could not be read, no operations were run");
            $display("Simulation failed");
            $finish;
        end else begin
            lineCount = opAddr.size();
            loaded    = 1'b1;
            repeat (5) @(posedge CLK);
            #1 rstN = 1'b1;
            for (int i = 0; i < lineCount; i++) begin
                driveOp(i);
            end
            // Park the bus on an unmapped address
            @(posedge CLK);
            #1;
            bus     = '0;
            opValid = 1'b0;
            while (!displayDone) begin
                @(posedge CLK);
            end
            $display("Done: %0d of %0d operations passed, %0d check failures",
                     passCount, lineCount, failCount);
            if (failCount == 0 && passCount == lineCount) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

    // Ops, then up to four full scans for the display to settle
    initial begin : watchdog
        int limit;
        wait (loaded);
        limit = lineCount * 2 + 4 * digitCount * scanDivider + 20;
        repeat (limit) @(posedge CLK);
        $display("Timeout: run did not finish within %0d cycles", limit);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/peripheralGolden.txt ====
# op addr wdata switches expected_rdata, all fields hex
# op W writes wdata to addr, op R checks rdata, expected_rdata is ignored for W
R FFFFFC60 00000000 0000 00000000
R FFFFFC80 00000000 0000 00000000
R FFFFFC70 00000000 A5C3 0000A5C3
R FFFFFC70 00000000 FFFF 0000FFFF
W FFFFFC70 12345678 0F0F 00000000
R FFFFFC70 00000000 0F0F 00000F0F
R FFFFFC60 00000000 0F0F 00000000
W FFFFFC60 DEADBEEF 0000 00000000
R FFFFFC60 00000000 0000 0000BEEF
W FFFFFC60 00011234 0000 00000000
W FFFFFC60 0000FFFF 0000 00000000
R FFFFFC60 00000000 0000 0000FFFF
W FFFFFC80 01234567 0000 00000000
R FFFFFC80 00000000 0000 01234567
R FFFFFC60 00000000 0000 0000FFFF
W FFFFFD00 FFFFFFFF 0000 00000000
R FFFFFD00 00000000 0000 00000000
R 00000000 00000000 0000 00000000
R FFFFFC64 00000000 0000 00000000
R FFFFFC80 00000000 0000 01234567
W FFFFFC80 89ABCDEF 0000 00000000
R FFFFFC80 00000000 0000 89ABCDEF
R FFFFFC70 00000000 8001 00008001
W FFFFFC60 00005A5A 8001 00000000
R FFFFFC60 00000000 8001 00005A5A
W FFFFFC84 FFFFFFFF 0000 00000000
R FFFFFC80 00000000 0000 89ABCDEF
R FFFFFC84 00000000 0000 00000000

// ==== project.f ====
common/ioBusPkg.sv
common/displayPkg.sv
verilog/peripheralConnector.sv
verilog/ledDriver.sv
segment/segmentDriver.sv
segment/segmentScanner.sv
verilog/peripheralTop.sv
tb/peripheralChecker.sv
tb/peripheralTb.sv

// ==== Makefile ====
SOURCES := $(shell cat project.f)

.PHONY: all run clean

all: run

obj_dir/VperipheralTb: project.f $(SOURCES)
	verilator --binary --timing --assert -j 0 -Mdir obj_dir \
		--top-module peripheralTb -f project.f

run: obj_dir/VperipheralTb
	@out="$$(./obj_dir/VperipheralTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
